/* logic/commitCounter.sv */
`default_nettype none
`include "stData_config.svh"

module commitCounter import storePkg::*; (
    input wire clk,
    input wire rst,
    input wire commit,
    input wire drainDone,
    output StSqN_t headSqN,
    output logic pending
);

    // One extra bit so a full window of credits fits.
    logic [`SQN_BITS:0] credits;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= '0;
            headSqN <= '0;
        end else begin
            if (commit && !drainDone) begin
                credits <= credits + 1'b1;
            end else if (drainDone && !commit) begin
                credits <= credits - 1'b1;
            end
            if (drainDone) begin
                headSqN <= headSqN + 1'b1;
            end
        end
    end

    assign pending = credits != '0;

    drainHasCredit: assert property (@(posedge clk) disable iff (rst)
        drainDone |-> credits != '0);

endmodule

`default_nettype wire

/* logic/drainCtrl.sv */
`default_nettype none

module drainCtrl import regPkg::*, storePkg::*; (
    input wire clk,
    input wire rst,
    input wire pending,
    input wire headReady,
    input wire RegT headData,
    input wire StSqN_t headSqN,
    output logic drainDone,
    output logic storeValid,
    output StSqN_t storeSqN,
    output RegT storeData
);

    DrainState state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DR_IDLE;
            storeValid <= 1'b0;
        end else begin
            storeValid <= 1'b0;
            case (state)
                DR_IDLE: begin
                    if (pending) begin
                        state <= DR_WAIT;
                    end
                end
                DR_WAIT: begin
                    // Head is committed and waits for its data.
                    if (headReady) begin
                        state <= DR_SEND;
                        storeValid <= 1'b1;
                    end
                end
                default: state <= DR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DR_WAIT && headReady) begin
            storeSqN <= headSqN;
            storeData <= headData;
        end
    end

    // Head advances at the end of the send cycle.
    assign drainDone = state == DR_SEND;

endmodule

`default_nettype wire

/* logic/regFile.sv */
`default_nettype none
`include "stData_config.svh"

module regFile import regPkg::*; #(
    parameter int WIDTH = `ST_WIDTH
) (
    input wire clk,
    input wire rst,
    input wire wrEn,
    input wire RFTag wrTag,
    input wire RegT wrData,
    input wire RFTag rdTag[WIDTH-1:0],
    output RegT rdData[WIDTH-1:0]
);

    localparam int NUM_REGS = 2 ** $bits(RFTag);

    RegT regs[NUM_REGS];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            regs[wrTag] <= wrData;
        end
    end

    // A same-cycle write is not forwarded to the read data.
    always_ff @(posedge clk) begin
        for (int i = 0; i < WIDTH; i++) begin
            if (rst) begin
                rdData[i] <= '0;
            end else begin
                rdData[i] <= regs[rdTag[i]];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/regPkg.sv */
`default_nettype none
`include "stData_config.svh"

package regPkg;

    typedef logic [`REG_BITS-1:0] RegT;

    // MSB set means the low bits hold a signed immediate.
    typedef logic [`TAG_BITS-1:0] Tag;

    typedef logic [`TAG_BITS-2:0] RFTag;

    // Byte offset of the store within the word.
    typedef logic [1:0] StOff_t;

endpackage

`default_nettype wire

/* logic/stDataTop.sv */
`default_nettype none
`include "stData_config.svh"

module stDataTop import regPkg::*, storePkg::*; #(
    parameter int WIDTH = `ST_WIDTH
) (
    input wire clk,
    input wire rst,
    input wire branchTaken,
    input wire branchFlush,
    input wire StSqN_t branchSqN,
    input wire uopValid[WIDTH-1:0],
    input wire Tag uopTag[WIDTH-1:0],
    input wire StOff_t uopOffs[WIDTH-1:0],
    input wire StSqN_t uopSqN[WIDTH-1:0],
    output logic ready[WIDTH-1:0],
    input wire atoValid[WIDTH-1:0],
    input wire StSqN_t atoSqN[WIDTH-1:0],
    input wire RegT atoResult[WIDTH-1:0],
    input wire rfWrEn,
    input wire RFTag rfWrTag,
    input wire RegT rfWrData,
    input wire commit,
    output logic storeValid,
    output StSqN_t storeSqN,
    output RegT storeData
);

    RFTag rdTag[WIDTH-1:0];
    RegT rdData[WIDTH-1:0];
    logic sdValid[WIDTH-1:0];
    StSqN_t sdSqN[WIDTH-1:0];
    RegT sdData[WIDTH-1:0];
    StSqN_t headSqN;
    logic pending;
    logic headReady;
    RegT headData;
    logic drainDone;

    regFile #(.WIDTH(WIDTH)) regFile0 (
        .clk(clk),
        .rst(rst),
        .wrEn(rfWrEn),
        .wrTag(rfWrTag),
        .wrData(rfWrData),
        .rdTag(rdTag),
        .rdData(rdData)
    );

    storeDataLoad #(.WIDTH(WIDTH)) load0 (
        .clk(clk),
        .rst(rst),
        .branchTaken(branchTaken),
        .branchFlush(branchFlush),
        .branchSqN(branchSqN),
        .uopValid(uopValid),
        .uopTag(uopTag),
        .uopOffs(uopOffs),
        .uopSqN(uopSqN),
        .ready(ready),
        .atoValid(atoValid),
        .atoSqN(atoSqN),
        .atoResult(atoResult),
        .rdValid(),
        .rdTag(rdTag),
        .rdData(rdData),
        .sdValid(sdValid),
        .sdSqN(sdSqN),
        .sdData(sdData)
    );

    storeDataBuffer #(.WIDTH(WIDTH)) buffer0 (
        .clk(clk),
        .rst(rst),
        .branchTaken(branchTaken),
        .branchFlush(branchFlush),
        .branchSqN(branchSqN),
        .sdValid(sdValid),
        .sdSqN(sdSqN),
        .sdData(sdData),
        .headSqN(headSqN),
        .drainDone(drainDone),
        .headReady(headReady),
        .headData(headData)
    );

    commitCounter commit0 (
        .clk(clk),
        .rst(rst),
        .commit(commit),
        .drainDone(drainDone),
        .headSqN(headSqN),
        .pending(pending)
    );

    drainCtrl drain0 (
        .clk(clk),
        .rst(rst),
        .pending(pending),
        .headReady(headReady),
        .headData(headData),
        .headSqN(headSqN),
        .drainDone(drainDone),
        .storeValid(storeValid),
        .storeSqN(storeSqN),
        .storeData(storeData)
    );

endmodule

`default_nettype wire

/* logic/stData_config.svh */
`ifndef ST_DATA_CONFIG_SVH
`define ST_DATA_CONFIG_SVH

// Issue lanes into the store-data path.
`define ST_WIDTH 2

`define REG_BITS 32

// Top tag bit selects an immediate operand.
`define TAG_BITS 7

`define SQN_BITS 6
`define SDB_DEPTH 8

`endif

/* logic/storeDataBuffer.sv */
`default_nettype none
`include "stData_config.svh"

module storeDataBuffer import regPkg::*, storePkg::*; #(
    parameter int WIDTH = `ST_WIDTH,
    parameter int DEPTH = `SDB_DEPTH
) (
    input wire clk,
    input wire rst,
    input wire branchTaken,
    input wire branchFlush,
    input wire StSqN_t branchSqN,
    input wire sdValid[WIDTH-1:0],
    input wire StSqN_t sdSqN[WIDTH-1:0],
    input wire RegT sdData[WIDTH-1:0],
    input wire StSqN_t headSqN,
    input wire drainDone,
    output logic headReady,
    output RegT headData
);

    RegT entryData[DEPTH];
    StSqN_t entrySqN[DEPTH];
    logic [DEPTH-1:0] entryValid;
    logic wrEn[WIDTH-1:0];
    SdbIdx_t headIdx;

    assign headIdx = SdbIdx_t'(headSqN);
    assign headReady = entryValid[headIdx] && entrySqN[headIdx] == headSqN;
    assign headData = entryData[headIdx];

    // Results killed by this cycle's branch are dropped.
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            wrEn[i] = sdValid[i] && !isKilled(branchTaken, branchFlush, branchSqN, sdSqN[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else begin
            for (int e = 0; e < DEPTH; e++) begin
                if (isKilled(branchTaken, branchFlush, branchSqN, entrySqN[e])) begin
                    entryValid[e] <= 1'b0;
                end
            end
            if (drainDone) begin
                entryValid[headIdx] <= 1'b0;
            end
            for (int i = 0; i < WIDTH; i++) begin
                if (wrEn[i]) begin
                    entryValid[SdbIdx_t'(sdSqN[i])] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < WIDTH; i++) begin
            if (wrEn[i]) begin
                entryData[SdbIdx_t'(sdSqN[i])] <= sdData[i];
                entrySqN[SdbIdx_t'(sdSqN[i])] <= sdSqN[i];
            end
        end
    end

    for (genvar i = 0; i < WIDTH; i++) begin : gChk
        noOverwrite: assert property (@(posedge clk) disable iff (rst)
            wrEn[i] |-> !entryValid[SdbIdx_t'(sdSqN[i])]);
    end

endmodule

`default_nettype wire

/* logic/storeDataLoad.sv */
`default_nettype none
`include "stData_config.svh"

module storeDataLoad import regPkg::*, storePkg::*; #(
    parameter int WIDTH = `ST_WIDTH
) (
    input wire clk,
    input wire rst,
    input wire branchTaken,
    input wire branchFlush,
    input wire StSqN_t branchSqN,
    input wire uopValid[WIDTH-1:0],
    input wire Tag uopTag[WIDTH-1:0],
    input wire StOff_t uopOffs[WIDTH-1:0],
    input wire StSqN_t uopSqN[WIDTH-1:0],
    output logic ready[WIDTH-1:0],
    input wire atoValid[WIDTH-1:0],
    input wire StSqN_t atoSqN[WIDTH-1:0],
    input wire RegT atoResult[WIDTH-1:0],
    output logic rdValid[WIDTH-1:0],
    output RFTag rdTag[WIDTH-1:0],
    input wire RegT rdData[WIDTH-1:0],
    output logic sdValid[WIDTH-1:0],
    output StSqN_t sdSqN[WIDTH-1:0],
    output RegT sdData[WIDTH-1:0]
);

    // Only the placed bytes are defined.
    function automatic RegT shiftData(RegT raw, StOff_t offs);
        RegT shifted;
        shifted = 'x;
        case (offs)
            2'd0: shifted = raw;
            2'd1: shifted[15:8] = raw[7:0];
            2'd2: shifted[31:16] = raw[15:0];
            default: shifted[31:24] = raw[7:0];
        endcase
        return shifted;
    endfunction

    for (genvar i = 0; i < WIDTH; i++) begin : gLane
        logic heldValid;
        StSqN_t heldSqN;
        RegT heldData;
        logic lookup;
        StOff_t lookupOffs;
        RegT rdShifted;
        RegT immValue;
        logic accept;

        assign immValue = {{($bits(RegT) - $bits(RFTag)){uopTag[i][$bits(RFTag)-1]}},
                           uopTag[i][$bits(RFTag)-1:0]};
        assign rdShifted = shiftData(rdData[i], lookupOffs);

        // Stall only when an atomic result takes the lane output.
        assign ready[i] = !(atoValid[i] && heldValid);
        assign rdValid[i] = uopValid[i] && !uopTag[i][$bits(Tag)-1];
        assign rdTag[i] = uopTag[i][$bits(RFTag)-1:0];
        assign accept = uopValid[i] && ready[i] &&
                        !isKilled(branchTaken, branchFlush, branchSqN, uopSqN[i]);

        always_ff @(posedge clk) begin
            if (rst) begin
                heldValid <= 1'b0;
                lookup <= 1'b0;
            end else begin
                lookup <= accept && rdValid[i];
                // Held uop leaves once it has gone out without an atomic.
                if (!atoValid[i] || isKilled(branchTaken, branchFlush, branchSqN, heldSqN)) begin
                    heldValid <= 1'b0;
                end
                if (accept) begin
                    heldValid <= 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (lookup) begin
                heldData <= rdShifted;
            end
            if (accept) begin
                heldSqN <= uopSqN[i];
                lookupOffs <= uopOffs[i];
                if (!rdValid[i]) begin
                    heldData <= shiftData(immValue, uopOffs[i]);
                end
            end
        end

        // Atomic result wins the lane.
        always_comb begin
            sdValid[i] = atoValid[i] || heldValid;
            sdSqN[i] = atoValid[i] ? atoSqN[i] : heldSqN;
            if (atoValid[i]) begin
                sdData[i] = atoResult[i];
            end else if (lookup) begin
                sdData[i] = rdShifted;
            end else begin
                sdData[i] = heldData;
            end
        end

        lookupHeld: assert property (@(posedge clk) disable iff (rst) lookup |-> heldValid);
    end

endmodule

`default_nettype wire

/* logic/storePkg.sv */
`default_nettype none
`include "stData_config.svh"

package storePkg;

    typedef logic [`SQN_BITS-1:0] StSqN_t;
    typedef logic [$clog2(`SDB_DEPTH)-1:0] SdbIdx_t;

    typedef enum logic [1:0] {DR_IDLE, DR_WAIT, DR_SEND} DrainState;

    // Wraparound compare where a positive difference means younger than the branch.
    function automatic logic isKilled(logic taken, logic flush, StSqN_t brSqN, StSqN_t sqN);
        StSqN_t diff;
        diff = sqN - brSqN;
        return taken && (flush || $signed(diff) > 0);
    endfunction

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the store-data testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f stData.f --top-module stDataTb -o stDataSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/stDataSim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG" || [ $status -ne 0 ]; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"
exit 0

/* stData.f */
+incdir+logic
logic/regPkg.sv
logic/storePkg.sv
logic/regFile.sv
logic/storeDataLoad.sv
logic/storeDataBuffer.sv
logic/commitCounter.sv
logic/drainCtrl.sv
logic/stDataTop.sv
verification/stDataTb.sv

/* verification/stDataTb.sv */
`default_nettype none
`include "stData_config.svh"

module stDataTb import regPkg::*, storePkg::*; ();

    localparam int WIDTH = `ST_WIDTH;
    localparam int CLK_PERIOD = 20;
    localparam int NUM_REGS = 2 ** $bits(RFTag);
    localparam int NUM_SQN = 2 ** $bits(StSqN_t);

    typedef enum logic [2:0] {A_ISSUE, A_ATOMIC, A_BRANCH, A_FLUSH, A_COMMIT} Action;

    // Value is only read by atomic rows.
    typedef struct packed {
        Action kind;
        int lane;
        Tag tag;
        StOff_t offs;
        StSqN_t sqn;
        RegT value;
    } Row;

    logic clk;
    logic rst;
    logic branchTaken;
    logic branchFlush;
    StSqN_t branchSqN;
    logic uopValid[WIDTH-1:0];
    Tag uopTag[WIDTH-1:0];
    StOff_t uopOffs[WIDTH-1:0];
    StSqN_t uopSqN[WIDTH-1:0];
    logic ready[WIDTH-1:0];
    logic atoValid[WIDTH-1:0];
    StSqN_t atoSqN[WIDTH-1:0];
    RegT atoResult[WIDTH-1:0];
    logic rfWrEn;
    RFTag rfWrTag;
    RegT rfWrData;
    logic commit;
    logic storeValid;
    StSqN_t storeSqN;
    RegT storeData;

    Row rows[$];
    logic tableLoaded = 1'b0;
    RegT regModel[NUM_REGS];
    RegT expData[NUM_SQN];
    RegT expMask[NUM_SQN];
    int commitsSeen = 0;
    int drained = 0;
    int drainHead = 0;
    int nextCommit = 0;
    int heldLane = -1;

    stDataTop #(.WIDTH(WIDTH)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stopWithError(string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkData(string name, RegT got, RegT exp, RegT mask);
        if ((got & mask) !== (exp & mask)) begin
            stopWithError($sformatf("[FAIL] %s got 0x%08h expected 0x%08h mask 0x%08h",
                                    name, got, exp, mask));
        end
    endtask

    task automatic checkSqN(string name, StSqN_t got, StSqN_t exp);
        if (got !== exp) begin
            stopWithError($sformatf("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp));
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            stopWithError($sformatf("[FAIL] %s got 0x%01h expected 0x%01h", name, got, exp));
        end
    endtask

    // Immediates are the sign-extended low tag bits.
    function automatic RegT operandValue(Tag tag);
        int imm;
        imm = $signed(RFTag'(tag));
        if (tag[$bits(Tag)-1]) begin
            return RegT'(imm);
        end
        return regModel[RFTag'(tag)];
    endfunction

    function automatic RegT shiftByOffset(RegT value, StOff_t offs);
        return value << {offs, 3'b000};
    endfunction

    function automatic RegT placedMask(StOff_t offs);
        case (offs)
            2'd0: return '1;
            2'd1: return 32'h0000_ff00;
            2'd2: return 32'hffff_0000;
            default: return 32'hff00_0000;
        endcase
    endfunction

    task automatic idleInputs();
        for (int i = 0; i < WIDTH; i++) begin
            uopValid[i] = 1'b0;
            uopTag[i] = '0;
            uopOffs[i] = '0;
            uopSqN[i] = '0;
            atoValid[i] = 1'b0;
            atoSqN[i] = '0;
            atoResult[i] = '0;
        end
        branchTaken = 1'b0;
        branchFlush = 1'b0;
        branchSqN = '0;
        rfWrEn = 1'b0;
        rfWrTag = '0;
        rfWrData = '0;
        commit = 1'b0;
    endtask

    task automatic addRow(Action kind, int lane, Tag tag, StOff_t offs, StSqN_t sqn, RegT value);
        Row r;
        r.kind = kind;
        r.lane = lane;
        r.tag = tag;
        r.offs = offs;
        r.sqn = sqn;
        r.value = value;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        // Register operands at every offset.
        addRow(A_ISSUE, 0, 7'h03, 2'd0, 6'd0, '0);
        addRow(A_ISSUE, 1, 7'h11, 2'd1, 6'd1, '0);
        addRow(A_ISSUE, 0, 7'h2a, 2'd2, 6'd2, '0);
        addRow(A_ISSUE, 1, 7'h3f, 2'd3, 6'd3, '0);
        addRow(A_ISSUE, 0, 7'h00, 2'd1, 6'd4, '0);
        addRow(A_ISSUE, 1, 7'h07, 2'd0, 6'd5, '0);
        addRow(A_ISSUE, 0, 7'h1c, 2'd3, 6'd6, '0);
        addRow(A_ISSUE, 1, 7'h25, 2'd2, 6'd7, '0);
        addRow(A_COMMIT, 0, '0, '0, 6'd7, '0);
        // Immediates of both signs.
        addRow(A_ISSUE, 0, 7'h7f, 2'd0, 6'd8, '0);
        addRow(A_ISSUE, 1, 7'h60, 2'd1, 6'd9, '0);
        addRow(A_ISSUE, 0, 7'h5f, 2'd2, 6'd10, '0);
        addRow(A_ISSUE, 1, 7'h41, 2'd3, 6'd11, '0);
        // Atomics land on a lane that holds a uop.
        addRow(A_ISSUE, 0, 7'h12, 2'd2, 6'd12, '0);
        addRow(A_ATOMIC, 0, '0, '0, 6'd13, 32'ha5c3_0f96);
        addRow(A_ISSUE, 1, 7'h70, 2'd0, 6'd14, '0);
        addRow(A_ATOMIC, 1, '0, '0, 6'd15, 32'h5a3c_96e1);
        addRow(A_COMMIT, 0, '0, '0, 6'd15, '0);
        // 18 is buffered and 19 in flight when the branch hits.
        addRow(A_ISSUE, 0, 7'h05, 2'd0, 6'd16, '0);
        addRow(A_ISSUE, 1, 7'h46, 2'd1, 6'd17, '0);
        addRow(A_ISSUE, 0, 7'h33, 2'd0, 6'd18, '0);
        addRow(A_ISSUE, 1, 7'h0a, 2'd3, 6'd19, '0);
        addRow(A_BRANCH, 0, '0, '0, 6'd17, '0);
        addRow(A_ISSUE, 0, 7'h21, 2'd2, 6'd18, '0);
        addRow(A_ISSUE, 1, 7'h6b, 2'd0, 6'd19, '0);
        addRow(A_COMMIT, 0, '0, '0, 6'd19, '0);
        addRow(A_ISSUE, 0, 7'h09, 2'd1, 6'd20, '0);
        addRow(A_ISSUE, 1, 7'h2f, 2'd0, 6'd21, '0);
        addRow(A_FLUSH, 0, '0, '0, 6'd20, '0);
        addRow(A_ISSUE, 1, 7'h52, 2'd1, 6'd20, '0);
        addRow(A_ISSUE, 0, 7'h18, 2'd3, 6'd21, '0);
        addRow(A_ISSUE, 1, 7'h3a, 2'd0, 6'd22, '0);
        addRow(A_COMMIT, 0, '0, '0, 6'd22, '0);
    endtask

    // Ready is sampled once the falling-edge drive has settled.
    task automatic issueUop(int lane, Tag tag, StOff_t offs, StSqN_t sqn);
        uopValid[lane] = 1'b1;
        uopTag[lane] = tag;
        uopOffs[lane] = offs;
        uopSqN[lane] = sqn;
        #1;
        while (!ready[lane]) begin
            @(negedge clk);
            #1;
        end
        expData[sqn] = shiftByOffset(operandValue(tag), offs);
        expMask[sqn] = placedMask(offs);
    endtask

    task automatic presentAtomic(int lane, StSqN_t sqn, RegT value, logic expReady);
        atoValid[lane] = 1'b1;
        atoSqN[lane] = sqn;
        atoResult[lane] = value;
        #1;
        checkFlag("ready", ready[lane], expReady);
        expData[sqn] = value;
        expMask[sqn] = '1;
    endtask

    task automatic commitThrough(StSqN_t lastSqN);
        repeat (4) @(negedge clk);
        while (nextCommit <= int'(lastSqN)) begin
            commit = 1'b1;
            nextCommit++;
            @(negedge clk);
        end
        commit = 1'b0;
        while (drained != commitsSeen) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (!rst && commit) begin
            commitsSeen++;
        end
    end

    // Stores leave in sequence order with one per commit.
    always @(negedge clk) begin
        if (!rst && storeValid) begin
            if (drained >= commitsSeen) begin
                stopWithError("a store drained without an outstanding commit");
            end
            checkSqN("storeSqN", storeSqN, StSqN_t'(drainHead));
            checkData("storeData", storeData, expData[drainHead], expMask[drainHead]);
            drainHead <= drainHead + 1;
            drained <= drained + 1;
        end
    end

    initial begin
        wait (tableLoaded);
        #((rows.size() + 20) * 40 * CLK_PERIOD);
        stopWithError("watchdog timeout, the stores did not finish draining in time");
    end

    initial begin
        void'($urandom(34466));
        rst = 1'b1;
        idleInputs();
        buildTable();
        tableLoaded = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < NUM_REGS; r++) begin
            @(negedge clk);
            rfWrEn = 1'b1;
            rfWrTag = RFTag'(r);
            rfWrData = $urandom();
            regModel[r] = rfWrData;
        end
        foreach (rows[n]) begin
            @(negedge clk);
            idleInputs();
            case (rows[n].kind)
                A_ISSUE: issueUop(rows[n].lane, rows[n].tag, rows[n].offs, rows[n].sqn);
                A_ATOMIC: presentAtomic(rows[n].lane, rows[n].sqn, rows[n].value,
                                        heldLane != rows[n].lane);
                A_BRANCH, A_FLUSH: begin
                    branchTaken = 1'b1;
                    branchFlush = rows[n].kind == A_FLUSH;
                    branchSqN = rows[n].sqn;
                end
                default: commitThrough(rows[n].sqn);
            endcase
            heldLane = (rows[n].kind == A_ISSUE) ? rows[n].lane : -1;
        end
        @(negedge clk);
        idleInputs();
        repeat (10) @(negedge clk);
        if (drained != commitsSeen || drained != nextCommit) begin
            stopWithError($sformatf("%0d stores drained for %0d commits", drained, commitsSeen));
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
